//--- dv/rasterizer_unit_checker.sv
module rasterizer_unit_checker #(
    parameter int MEM_AW = 11
) (
    input logic                 clock,
    input logic                 rst_n,
    input raster_pkg::mem_req_t vtx_req,
    input raster_pkg::mem_rsp_t vtx_rsp,
    input raster_pkg::mem_req_t zrd_req,
    input raster_pkg::mem_rsp_t zrd_rsp,
    input raster_pkg::mem_req_t fb_req,
    input raster_pkg::mem_rsp_t fb_rsp,
    input logic                 do_render,
    input logic                 done_pulse
);

    timeunit 1ns;
    timeprecision 1ps;

    int                            fail_count = 0;
    logic [7:0]                    seen_depth [2**MEM_AW]; // last depth read per word
    logic [raster_pkg::ADDR_W-1:0] rd_addr_q;
    logic                          idle_q;
    logic                          depth_lower;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr_q <= '0;
            idle_q    <= 1'b1;
        end else begin
            if (zrd_req.read && !zrd_rsp.waitrequest)
                rd_addr_q <= zrd_req.address;
            if (do_render)
                idle_q <= 1'b0;
            else if (done_pulse)
                idle_q <= 1'b1; // render over
        end
    end

    always_ff @(posedge clock) begin
        if (zrd_rsp.readdatavalid)
            seen_depth[rd_addr_q[MEM_AW-1:0]] <= zrd_rsp.readdata[31:24];
    end

    assign depth_lower = fb_req.writedata[31:24] < seen_depth[fb_req.address[MEM_AW-1:0]];

    vtx_stable: assert property (@(posedge clock) disable iff (!rst_n)
        (vtx_req.read && vtx_rsp.waitrequest) |=> $stable(vtx_req))
    else begin
        $error("vertex read request changed while waitrequest was high");
        fail_count++;
    end

    zrd_stable: assert property (@(posedge clock) disable iff (!rst_n)
        (zrd_req.read && zrd_rsp.waitrequest) |=> $stable(zrd_req))
    else begin
        $error("depth read request changed while waitrequest was high");
        fail_count++;
    end

    fb_stable: assert property (@(posedge clock) disable iff (!rst_n)
        (fb_req.write && fb_rsp.waitrequest) |=> $stable(fb_req))
    else begin
        $error("pixel write request changed while waitrequest was high");
        fail_count++;
    end

    write_nearer: assert property (@(posedge clock) disable iff (!rst_n)
        fb_req.write |-> depth_lower)
    else begin
        $error("pixel write depth is not below the depth read at that address");
        fail_count++;
    end

    no_late_write: assert property (@(posedge clock) disable iff (!rst_n)
        idle_q |-> !fb_req.write)
    else begin
        $error("pixel write seen after the render finished");
        fail_count++;
    end

endmodule

bind rasterizer_unit rasterizer_unit_checker chk0 (
    .clock(clock),
    .rst_n(rst_n),
    .vtx_req(vtx_req),
    .vtx_rsp(vtx_rsp),
    .zrd_req(zrd_req),
    .zrd_rsp(zrd_rsp),
    .fb_req(fb_req),
    .fb_rsp(fb_rsp),
    .do_render(do_render),
    .done_pulse(done_zt)
);

//--- dv/rasterizer_unit_tb.sv
module rasterizer_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SCREEN_W_LOG2 = 5;
    localparam int SCREEN_W = 1 << SCREEN_W_LOG2;
    localparam int SCREEN_H = 16;
    localparam int FB_WORDS = SCREEN_W * SCREEN_H;
    localparam int MEM_WORDS = 2048;
    localparam int VTX_BASE = 'h40;
    localparam int FB_BASE = 'h100;
    localparam logic [31:0] FB_CLEAR = 32'hff00_0000; // far depth and black
    // about 650 covered pixels at up to 20 cycles each plus margin
    localparam int MAX_CYCLES = 20000;

    logic                 clock;
    logic                 rst_n;
    logic [31:0]          writedata;
    logic                 write;
    logic                 read;
    logic [15:0]          address;
    logic [31:0]          readdata;
    raster_pkg::mem_req_t vtx_req;
    raster_pkg::mem_rsp_t vtx_rsp;
    raster_pkg::mem_req_t zrd_req;
    raster_pkg::mem_rsp_t zrd_rsp;
    raster_pkg::mem_req_t fb_req;
    raster_pkg::mem_rsp_t fb_rsp;

    raster_pkg::mem_req_t req_a [3];
    raster_pkg::mem_rsp_t rsp_a [3];
    logic [31:0]          mem [MEM_WORDS];
    logic [31:0]          model_fb [FB_WORDS];
    int                   rd_cnt [3];
    logic [10:0]          rd_addr [3];
    int                   errors;
    int                   cycles;
    int                   tri_n;
    int                   starts_seen;

    rasterizer_unit #(.SCREEN_W_LOG2(SCREEN_W_LOG2)) dut0 (.*);

    assign req_a[0] = vtx_req;
    assign req_a[1] = zrd_req;
    assign req_a[2] = fb_req;
    assign vtx_rsp  = rsp_a[0];
    assign zrd_rsp  = rsp_a[1];
    assign fb_rsp   = rsp_a[2];

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: render did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks failed");
        $finish;
    end

    always @(negedge clock) begin
        if (dut0.do_render)
            starts_seen++;
    end

    // one word array behind all three masters
    initial begin : mem_model
        void'($urandom(6));
        forever begin
            @(negedge clock); // mid cycle with the bus settled
            for (int i = 0; i < 3; i++) begin
                if (req_a[i].write && !rsp_a[i].waitrequest) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req_a[i].byteenable[b])
                            mem[req_a[i].address[10:0]][8*b +: 8] =
                                req_a[i].writedata[8*b +: 8];
                    end
                end
                if (req_a[i].read && !rsp_a[i].waitrequest) begin
                    rd_cnt[i]  = 1 + int'($urandom % 4);
                    rd_addr[i] = req_a[i].address[10:0];
                end
            end
            @(posedge clock);
            #2;
            for (int i = 0; i < 3; i++) begin
                rsp_a[i].waitrequest   = ($urandom % 3 == 0);
                rsp_a[i].readdatavalid = 1'b0;
                if (rd_cnt[i] > 0) begin
                    rd_cnt[i]--;
                    if (rd_cnt[i] == 0) begin
                        rsp_a[i].readdatavalid = 1'b1;
                        rsp_a[i].readdata      = mem[rd_addr[i]];
                    end
                end
            end
        end
    end

    task automatic host_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge clock);
        #2;
        write     = 1'b1;
        address   = addr;
        writedata = data;
        @(posedge clock);
        #2;
        write = 1'b0;
    endtask

    task automatic host_read(input logic [15:0] addr, output logic [31:0] data);
        @(posedge clock);
        #2;
        read    = 1'b1;
        address = addr;
        @(posedge clock);
        #2;
        read = 1'b0;
        data = readdata;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    function automatic int edge_value(input int ax, ay, bx, by, px, py);
        return (bx - ax) * (py - ay) - (by - ay) * (px - ax);
    endfunction

    function automatic int smallest(input int a, b, c);
        int m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic int largest(input int a, b, c);
        int m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // flat depth test over the bounding box for both windings
    task automatic paint_model(input int x1, y1, x2, y2, x3, y3, input logic [31:0] attr);
        int e0;
        int e1;
        int e2;
        int idx;
        if (edge_value(x1, y1, x2, y2, x3, y3) == 0)
            return;
        for (int y = smallest(y1, y2, y3); y <= largest(y1, y2, y3); y++) begin
            for (int x = smallest(x1, x2, x3); x <= largest(x1, x2, x3); x++) begin
                e0 = edge_value(x1, y1, x2, y2, x, y);
                e1 = edge_value(x2, y2, x3, y3, x, y);
                e2 = edge_value(x3, y3, x1, y1, x, y);
                if ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0)) begin
                    idx = y * SCREEN_W + x;
                    if (attr[31:24] < model_fb[idx][31:24])
                        model_fb[idx] = attr;
                end
            end
        end
    endtask

    task automatic add_triangle(input int x1, y1, x2, y2, x3, y3, input logic [31:0] attr);
        int base;
        base = VTX_BASE + tri_n * 6;
        mem[base]     = {16'(x1), 16'(y1)};
        mem[base + 1] = attr;
        mem[base + 2] = {16'(x2), 16'(y2)};
        mem[base + 3] = 32'h0;
        mem[base + 4] = {16'(x3), 16'(y3)};
        mem[base + 5] = 32'h0;
        tri_n++;
        paint_model(x1, y1, x2, y2, x3, y3, attr);
    endtask

    task automatic clear_frame();
        for (int i = 0; i < FB_WORDS; i++) begin
            mem[FB_BASE + i] = FB_CLEAR;
            model_fb[i]      = FB_CLEAR;
        end
        tri_n = 0;
    endtask

    task automatic wait_done();
        logic [31:0] st;
        st = '0;
        while (!st[1])
            host_read(16'd1, st);
    endtask

    task automatic render_batch();
        host_write(16'd4, 32'(tri_n));
        host_write(16'd0, 32'd1);
        wait_done();
    endtask

    task automatic compare_frame();
        for (int i = 0; i < FB_WORDS; i++) begin
            if (mem[FB_BASE + i] !== model_fb[i]) begin
                $display("FAIL fb word at %h: expected %h, got %h",
                         FB_BASE + i, model_fb[i], mem[FB_BASE + i]);
                errors++;
            end
        end
    endtask

    initial begin : main
        logic [31:0] st;
        int starts_before;
        errors      = 0;
        starts_seen = 0;
        tri_n       = 0;
        rst_n       = 1'b0;
        write       = 1'b0;
        read        = 1'b0;
        address     = '0;
        writedata   = '0;
        for (int i = 0; i < 3; i++) begin
            rsp_a[i]   = '0;
            rd_cnt[i]  = 0;
            rd_addr[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'h0;
        repeat (3) @(posedge clock);
        #2;
        rst_n = 1'b1;

        host_write(16'd2, VTX_BASE);
        host_write(16'd3, FB_BASE);
        host_write(16'd4, 32'd5);
        host_read(16'd2, st);
        check_value("vertex_base", VTX_BASE, st);
        host_read(16'd3, st);
        check_value("fb_base", FB_BASE, st);
        host_read(16'd4, st);
        check_value("tri_count", 32'd5, st);

        clear_frame();
        add_triangle(2, 2, 12, 3, 5, 11, 32'h30_12abcd);
        render_batch();
        compare_frame();

        // clockwise then a degenerate line
        clear_frame();
        add_triangle(20, 2, 22, 12, 30, 4, 32'h50_00ff00);
        add_triangle(1, 14, 5, 14, 9, 14, 32'h10_ffffff);
        render_batch();
        compare_frame();

        // nearer, farther and equal depth over shared pixels
        clear_frame();
        add_triangle(4, 1, 20, 2, 8, 12, 32'h80_ff0000);
        add_triangle(6, 3, 24, 6, 10, 14, 32'h40_00ff00);
        add_triangle(2, 4, 18, 8, 6, 13, 32'hc0_0000ff);
        add_triangle(8, 2, 16, 10, 5, 9, 32'h40_ffffff);
        render_batch();
        compare_frame();

        clear_frame();
        add_triangle(3, 1, 28, 6, 10, 15, 32'h20_808080);
        host_write(16'd4, 32'(tri_n));
        starts_before = starts_seen;
        host_write(16'd0, 32'd1);
        host_read(16'd1, st);
        check_value("status", 32'h1, st);
        host_write(16'd0, 32'd1); // lands while busy
        wait_done();
        host_read(16'd1, st);
        check_value("status", 32'h2, st);
        check_value("do_render pulses", 32'(starts_before + 1), 32'(starts_seen));
        compare_frame();

        host_write(16'd4, 32'd0);
        host_write(16'd0, 32'd1);
        host_read(16'd1, st);
        check_value("status", 32'h1, st);
        wait_done();
        host_read(16'd1, st);
        check_value("status", 32'h2, st);

        $display("check errors: %0d, assertion failures: %0d", errors, dut0.chk0.fail_count);
        if (errors == 0 && dut0.chk0.fail_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- project.f
rtl/raster_pkg.sv
rtl/raster_config_regs.sv
rtl/raster_vertex_fetch.sv
rtl/raster_edge_walker.sv
rtl/raster_depth_fetch.sv
rtl/raster_depth_test.sv
rtl/rasterizer_unit.sv
dv/rasterizer_unit_checker.sv
dv/rasterizer_unit_tb.sv

//--- rtl/raster_config_regs.sv
module raster_config_regs (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic [31:0]                   writedata,
    input  logic                          write,
    input  logic                          read,
    input  logic [15:0]                   address,
    input  logic                          done_in,
    output logic [31:0]                   readdata,
    output logic [raster_pkg::ADDR_W-1:0] vertex_base,
    output logic [raster_pkg::ADDR_W-1:0] fb_base,
    output logic [15:0]                   tri_count,
    output logic                          do_render
);

    logic busy;
    logic done;
    logic start;

    // start is dropped while a render runs
    assign start = write && (address == 16'd0) && writedata[0] && !busy;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            do_render   <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
            vertex_base <= '0;
            fb_base     <= '0;
            tri_count   <= '0;
        end else begin
            do_render <= start;
            if (start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (done_in) begin
                busy <= 1'b0;
                done <= 1'b1; // sticky until next start
            end
            if (write) begin
                case (address)
                    16'd2:   vertex_base <= writedata[raster_pkg::ADDR_W-1:0];
                    16'd3:   fb_base <= writedata[raster_pkg::ADDR_W-1:0];
                    16'd4:   tri_count <= writedata[15:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (read) begin
            case (address)
                16'd1:   readdata <= {30'd0, done, busy};
                16'd2:   readdata <= 32'(vertex_base);
                16'd3:   readdata <= 32'(fb_base);
                16'd4:   readdata <= {16'd0, tri_count};
                default: readdata <= '0;
            endcase
        end
    end

endmodule

//--- rtl/raster_depth_fetch.sv
module raster_depth_fetch (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 pix_valid,
    input  raster_pkg::pixel_t   pix_in,
    input  raster_pkg::mem_rsp_t zrd_rsp,
    input  logic                 stall_in,
    input  logic                 done_in,
    output raster_pkg::mem_req_t zrd_req,
    output logic                 stall_out,
    output logic                 pair_valid,
    output raster_pkg::pixel_t   new_pix,
    output raster_pkg::pattr_t   old_attr,
    output logic                 done_out
);

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT, S_OUT} state_t;

    state_t                 state;
    logic                   done_pend;
    raster_pkg::vbuf_word_u rd_word;

    assign rd_word = zrd_rsp.readdata;

    assign zrd_req.address    = new_pix.addr;
    assign zrd_req.read       = (state == S_REQ);
    assign zrd_req.write      = 1'b0;
    assign zrd_req.byteenable = 4'hf;
    assign zrd_req.writedata  = '0;

    assign stall_out  = (state != S_IDLE); // one pixel in flight
    assign pair_valid = (state == S_OUT);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            done_pend <= 1'b0;
            done_out  <= 1'b0;
        end else begin
            done_out <= 1'b0;
            if (done_in) begin
                done_pend <= 1'b1;
            end else if (done_pend && state == S_IDLE) begin
                done_pend <= 1'b0;
                done_out  <= 1'b1;
            end
            case (state)
                S_IDLE:  if (pix_valid) state <= S_REQ;
                S_REQ:   if (!zrd_rsp.waitrequest) state <= S_WAIT;
                S_WAIT:  if (zrd_rsp.readdatavalid) state <= S_OUT;
                S_OUT:   if (!stall_in) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_IDLE && pix_valid)
            new_pix <= pix_in;
        if (state == S_WAIT && zrd_rsp.readdatavalid)
            old_attr <= rd_word.attr; // stored depth and colour
    end

endmodule

//--- rtl/raster_depth_test.sv
module raster_depth_test (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 pair_valid,
    input  raster_pkg::pixel_t   new_pix,
    input  raster_pkg::pattr_t   old_attr,
    input  raster_pkg::mem_rsp_t fb_rsp,
    input  logic                 done_in,
    output raster_pkg::mem_req_t fb_req,
    output logic                 stall_out,
    output logic                 done_out
);

    typedef enum logic [1:0] {S_IDLE, S_DECIDE, S_WRITE} state_t;

    state_t             state;
    raster_pkg::pixel_t pix_q;
    logic [7:0]         old_depth;
    logic               win;
    logic               finish;
    logic               done_pend;

    assign win    = (pix_q.attr.depth < old_depth); // equal depth loses
    assign finish = (state == S_DECIDE && !win) || (state == S_WRITE && !fb_rsp.waitrequest);

    // end of render seen in the same cycle as the last write or drop
    assign done_out  = (done_in || done_pend) && (state == S_IDLE || finish);
    assign stall_out = (state != S_IDLE);

    assign fb_req.address    = pix_q.addr;
    assign fb_req.read       = 1'b0;
    assign fb_req.write      = (state == S_WRITE);
    assign fb_req.byteenable = 4'hf;
    assign fb_req.writedata  = pix_q.attr;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            done_pend <= 1'b0;
        end else begin
            done_pend <= (done_pend || done_in) && !done_out;
            case (state)
                S_IDLE:   if (pair_valid) state <= S_DECIDE;
                S_DECIDE: state <= win ? S_WRITE : S_IDLE;
                S_WRITE:  if (!fb_rsp.waitrequest) state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_IDLE && pair_valid) begin
            pix_q     <= new_pix;
            old_depth <= old_attr.depth;
        end
    end

endmodule

//--- rtl/raster_edge_walker.sv
module raster_edge_walker #(
    parameter int SCREEN_W_LOG2 = 5
) (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          tri_valid,
    input  raster_pkg::tri_t              tri_in,
    input  logic [raster_pkg::ADDR_W-1:0] fb_base,
    input  logic                          stall_in,
    input  logic                          done_in,
    output logic                          stall_out,
    output logic                          pix_valid,
    output raster_pkg::pixel_t            pix_out,
    output logic                          done_out
);

    localparam int AW = raster_pkg::ADDR_W;

    typedef enum logic [1:0] {S_IDLE, S_SETUP1, S_SETUP2, S_SCAN} state_t;

    state_t             state;
    raster_pkg::tri_t   tri_q;
    logic [15:0]        x_min;
    logic [15:0]        x_max;
    logic [15:0]        y_min;
    logic [15:0]        y_max;
    logic [15:0]        cx;
    logic [15:0]        cy;
    logic [AW-1:0]      row_addr;
    logic               area_zero;
    logic signed [35:0] e0;
    logic signed [35:0] e1;
    logic signed [35:0] e2;
    logic               covered;
    logic               advance;
    logic               last_x;
    logic               empty;
    logic               done_pend;

    // (b - a) x (p - a)
    function automatic logic signed [35:0] edge_fn(input raster_pkg::vpos_t a,
                                                   input raster_pkg::vpos_t b,
                                                   input logic [15:0] px,
                                                   input logic [15:0] py);
        logic signed [16:0] ex;
        logic signed [16:0] ey;
        logic signed [16:0] qx;
        logic signed [16:0] qy;
        ex = $signed({1'b0, b.x}) - $signed({1'b0, a.x});
        ey = $signed({1'b0, b.y}) - $signed({1'b0, a.y});
        qx = $signed({1'b0, px}) - $signed({1'b0, a.x});
        qy = $signed({1'b0, py}) - $signed({1'b0, a.y});
        return ex * qy - ey * qx;
    endfunction

    function automatic logic [15:0] min3(input logic [15:0] a, b, c);
        logic [15:0] m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic logic [15:0] max3(input logic [15:0] a, b, c);
        logic [15:0] m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    assign e0 = edge_fn(tri_q.v1, tri_q.v2, cx, cy);
    assign e1 = edge_fn(tri_q.v2, tri_q.v3, cx, cy);
    assign e2 = edge_fn(tri_q.v3, tri_q.v1, cx, cy);

    // either winding
    assign covered = ((e0 >= 0) && (e1 >= 0) && (e2 >= 0)) ||
                     ((e0 <= 0) && (e1 <= 0) && (e2 <= 0));

    assign advance   = !(pix_valid && stall_in);
    assign last_x    = (cx == x_max);
    assign stall_out = (state != S_IDLE);
    assign empty     = (state == S_IDLE) && !pix_valid;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            pix_valid <= 1'b0;
            done_pend <= 1'b0;
            done_out  <= 1'b0;
        end else begin
            done_out <= 1'b0;
            if (done_in) begin
                done_pend <= 1'b1;
            end else if (done_pend && empty) begin
                done_pend <= 1'b0;
                done_out  <= 1'b1;
            end
            if (advance)
                pix_valid <= (state == S_SCAN) && covered;
            case (state)
                S_IDLE:   if (tri_valid) state <= S_SETUP1;
                S_SETUP1: state <= S_SETUP2;
                S_SETUP2: state <= area_zero ? S_IDLE : S_SCAN;
                S_SCAN:   if (advance && last_x && cy == y_max) state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        case (state)
            S_IDLE: if (tri_valid) tri_q <= tri_in;
            S_SETUP1: begin
                x_min     <= min3(tri_q.v1.x, tri_q.v2.x, tri_q.v3.x);
                x_max     <= max3(tri_q.v1.x, tri_q.v2.x, tri_q.v3.x);
                y_min     <= min3(tri_q.v1.y, tri_q.v2.y, tri_q.v3.y);
                y_max     <= max3(tri_q.v1.y, tri_q.v2.y, tri_q.v3.y);
                area_zero <= (edge_fn(tri_q.v1, tri_q.v2, tri_q.v3.x, tri_q.v3.y) == 0);
            end
            S_SETUP2: begin
                cx       <= x_min;
                cy       <= y_min;
                row_addr <= fb_base + (AW'(y_min) << SCREEN_W_LOG2);
            end
            S_SCAN: begin
                if (advance) begin
                    pix_out.addr <= row_addr + AW'(cx);
                    pix_out.attr <= tri_q.attr;
                    if (last_x) begin
                        cx       <= x_min;
                        cy       <= cy + 16'd1;
                        row_addr <= row_addr + (AW'(1) << SCREEN_W_LOG2);
                    end else begin
                        cx <= cx + 16'd1;
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

//--- rtl/raster_pkg.sv
package raster_pkg;

    localparam int ADDR_W = 26; // memory word address

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
    } vpos_t;

    // also the framebuffer word layout
    typedef struct packed {
        logic [7:0]  depth;
        logic [23:0] rgb;
    } pattr_t;

    // one memory word, decoded by position in the triangle record
    typedef union packed {
        vpos_t  pos;
        pattr_t attr;
    } vbuf_word_u;

    typedef struct packed {
        vpos_t  v1;
        vpos_t  v2;
        vpos_t  v3;
        pattr_t attr; // from vertex 1, flat
    } tri_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        pattr_t            attr;
    } pixel_t;

    typedef struct packed {
        logic [ADDR_W-1:0] address;
        logic              read;
        logic              write;
        logic [3:0]        byteenable;
        logic [31:0]       writedata;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] readdata;
        logic        readdatavalid;
        logic        waitrequest;
    } mem_rsp_t;

endpackage

//--- rtl/raster_vertex_fetch.sv
module raster_vertex_fetch (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          fetch_enable,
    input  logic [raster_pkg::ADDR_W-1:0] vertex_base,
    input  logic [15:0]                   tri_count,
    input  raster_pkg::mem_rsp_t          vtx_rsp,
    input  logic                          stall_in,
    output raster_pkg::mem_req_t          vtx_req,
    output logic                          tri_valid,
    output raster_pkg::tri_t              tri_out,
    output logic                          done_out
);

    localparam int AW = raster_pkg::ADDR_W;

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT, S_OUT} state_t;

    state_t                 state;
    logic [AW-1:0]          addr;
    logic [2:0]             word_idx;
    logic [15:0]            tris_left;
    raster_pkg::vbuf_word_u rd_word;

    assign rd_word = vtx_rsp.readdata;

    assign vtx_req.address    = addr;
    assign vtx_req.read       = (state == S_REQ);
    assign vtx_req.write      = 1'b0;
    assign vtx_req.byteenable = 4'hf;
    assign vtx_req.writedata  = '0;

    assign tri_valid = (state == S_OUT);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            addr      <= '0;
            word_idx  <= '0;
            tris_left <= '0;
            done_out  <= 1'b0;
        end else begin
            done_out <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (fetch_enable) begin
                        addr      <= vertex_base;
                        word_idx  <= '0;
                        tris_left <= tri_count;
                        if (tri_count == 16'd0)
                            done_out <= 1'b1; // nothing to draw
                        else
                            state <= S_REQ;
                    end
                end
                S_REQ: if (!vtx_rsp.waitrequest) state <= S_WAIT;
                S_WAIT: begin
                    if (vtx_rsp.readdatavalid) begin
                        addr <= addr + AW'(1);
                        if (word_idx == 3'd5) begin
                            word_idx <= '0;
                            state    <= S_OUT;
                        end else begin
                            word_idx <= word_idx + 3'd1;
                            state    <= S_REQ;
                        end
                    end
                end
                S_OUT: begin
                    if (!stall_in) begin
                        tris_left <= tris_left - 16'd1;
                        if (tris_left == 16'd1) begin
                            done_out <= 1'b1;
                            state    <= S_IDLE;
                        end else begin
                            state <= S_REQ;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // even words are positions, odd words attributes
    always_ff @(posedge clock) begin
        if (state == S_WAIT && vtx_rsp.readdatavalid) begin
            case (word_idx)
                3'd0:    tri_out.v1 <= rd_word.pos;
                3'd1:    tri_out.attr <= rd_word.attr;
                3'd2:    tri_out.v2 <= rd_word.pos;
                3'd4:    tri_out.v3 <= rd_word.pos;
                default: ; // attrs of v2, v3 unused, flat shading
            endcase
        end
    end

endmodule

//--- rtl/rasterizer_unit.sv
module rasterizer_unit #(
    parameter int SCREEN_W_LOG2 = 5
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic [31:0]          writedata,
    input  logic                 write,
    input  logic                 read,
    input  logic [15:0]          address,
    output logic [31:0]          readdata,
    output raster_pkg::mem_req_t vtx_req,
    input  raster_pkg::mem_rsp_t vtx_rsp,
    output raster_pkg::mem_req_t zrd_req,
    input  raster_pkg::mem_rsp_t zrd_rsp,
    output raster_pkg::mem_req_t fb_req,
    input  raster_pkg::mem_rsp_t fb_rsp
);

    logic [raster_pkg::ADDR_W-1:0] vertex_base;
    logic [raster_pkg::ADDR_W-1:0] fb_base;
    logic [15:0]                   tri_count;
    logic                          do_render;

    // stall runs upstream, done downstream
    logic stall_walk;
    logic stall_zrd;
    logic stall_zt;
    logic done_vf;
    logic done_ew;
    logic done_zf;
    logic done_zt;

    logic               tri_valid;
    raster_pkg::tri_t   tri_data;
    logic               pix_valid;
    raster_pkg::pixel_t pix_data;
    logic               pair_valid;
    raster_pkg::pixel_t new_pix;
    raster_pkg::pattr_t old_attr;

    raster_config_regs c_reg (
        .clock(clock),
        .rst_n(rst_n),
        .writedata(writedata),
        .write(write),
        .read(read),
        .address(address),
        .done_in(done_zt),
        .readdata(readdata),
        .vertex_base(vertex_base),
        .fb_base(fb_base),
        .tri_count(tri_count),
        .do_render(do_render)
    );

    raster_vertex_fetch vertex_fetch (
        .clock(clock),
        .rst_n(rst_n),
        .fetch_enable(do_render),
        .vertex_base(vertex_base),
        .tri_count(tri_count),
        .vtx_rsp(vtx_rsp),
        .stall_in(stall_walk),
        .vtx_req(vtx_req),
        .tri_valid(tri_valid),
        .tri_out(tri_data),
        .done_out(done_vf)
    );

    raster_edge_walker #(
        .SCREEN_W_LOG2(SCREEN_W_LOG2)
    ) raster (
        .clock(clock),
        .rst_n(rst_n),
        .tri_valid(tri_valid),
        .tri_in(tri_data),
        .fb_base(fb_base),
        .stall_in(stall_zrd),
        .done_in(done_vf),
        .stall_out(stall_walk),
        .pix_valid(pix_valid),
        .pix_out(pix_data),
        .done_out(done_ew)
    );

    raster_depth_fetch fetch_logic (
        .clock(clock),
        .rst_n(rst_n),
        .pix_valid(pix_valid),
        .pix_in(pix_data),
        .zrd_rsp(zrd_rsp),
        .stall_in(stall_zt),
        .done_in(done_ew),
        .zrd_req(zrd_req),
        .stall_out(stall_zrd),
        .pair_valid(pair_valid),
        .new_pix(new_pix),
        .old_attr(old_attr),
        .done_out(done_zf)
    );

    raster_depth_test z_test (
        .clock(clock),
        .rst_n(rst_n),
        .pair_valid(pair_valid),
        .new_pix(new_pix),
        .old_attr(old_attr),
        .fb_rsp(fb_rsp),
        .done_in(done_zf),
        .fb_req(fb_req),
        .stall_out(stall_zt),
        .done_out(done_zt)
    );

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module rasterizer_unit_tb \
    -f project.f -o rasterizer_sim
./obj_dir/rasterizer_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
if grep -q "All checks passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
